/* uart_macros.svh */
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// clock cycles per serial bit
// 16 cycles of a 10 ns clock gives a 160 ns bit
`define UART_CLKS_PER_BIT 16

// data bits per frame, lsb goes out first
`define UART_DATA_BITS 8

// entries per buffer
// also the credit grant a source starts with
`define UART_FIFO_DEPTH 4

// credit counter width
// must hold UART_FIFO_DEPTH
`define UART_CREDIT_W 3

`endif

/* uart_line_pkg.sv */
`include "uart_macros.svh"

package uart_line_pkg;

   // phase of a serial frame
   // idle    line high, waiting
   // start   the low start bit
   // data    eight data bits, lsb first
   // stop    the high stop bit
   typedef enum logic [1:0] {
      idle  = 2'd0,
      start = 2'd1,
      data  = 2'd2,
      stop  = 2'd3
   } line_state_e;

   // which data bit is on the line
   typedef logic [$clog2(`UART_DATA_BITS)-1:0] bit_idx_t;

   // cycle count inside one bit time
   // one spare bit of headroom over the bit length
   typedef logic [$clog2(`UART_CLKS_PER_BIT):0] bit_timer_t;

endpackage

/* uart_host_pkg.sv */
`include "uart_macros.svh"

package uart_host_pkg;

   // one data byte as seen by the host
   typedef logic [`UART_DATA_BITS-1:0] byte_t;

   // word moved between buffer and serial blocks
   // frame_err only means something on the receive path
   // tx path drives it low, serializer ignores it
   typedef struct packed {
      byte_t data;
      logic  frame_err;
   } rx_word_t;

   // credits a source may still spend
   typedef logic [`UART_CREDIT_W-1:0] credit_cnt_t;

endpackage

/* byte_link_if.sv */
`timescale 1ns/1ps

// one byte stream with credit return
// source only raises valid while it holds a credit
// sink pulses credit once per freed entry
interface byte_link_if;

   // one cycle per word
   logic                    valid;
   uart_host_pkg::rx_word_t word;

   // one cycle per freed entry, back toward the source
   logic                    credit;

   // producing side
   modport src (
      output valid,
      output word,
      input  credit
   );

   // consuming side
   modport snk (
      input  valid,
      input  word,
      output credit
   );

endinterface

/* byte_fifo.sv */
`timescale 1ns/1ps
`include "uart_macros.svh"

// circular byte buffer with credits on both sides
// upstream credits track the free entries
// downstream credits track what the sink can take
module byte_fifo #(
   parameter int DEPTH        = `UART_FIFO_DEPTH,
   parameter int INIT_CREDITS = DEPTH
) (
   input  logic      clk,
   input  logic      rst_n,
   byte_link_if.snk  up,
   byte_link_if.src  down
);

   localparam int AW = $clog2(DEPTH);

   // storage
   uart_host_pkg::rx_word_t mem [DEPTH];

   logic [AW-1:0]              wr_ptr;
   logic [AW-1:0]              rd_ptr;
   // one extra bit so full and empty differ
   logic [AW:0]                count;
   // credits granted by the downstream sink
   uart_host_pkg::credit_cnt_t out_cred;
   logic                       send;

   // an entry leaves when there is one and the sink can take it
   assign send = (count != '0) && (out_cred != '0);

   // payload path
   always_ff @(posedge clk) begin
      // upstream never writes without a credit, so no full check
      if (up.valid) begin
         mem[wr_ptr] <= up.word;
      end
      if (send) begin
         down.word <= mem[rd_ptr];
      end
   end

   // pointers, fill level, credits
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         out_cred   <= uart_host_pkg::credit_cnt_t'(INIT_CREDITS);
         down.valid <= 1'b0;
         up.credit  <= 1'b0;
      end else begin
         // pointers wrap by themselves, depth is a power of two
         if (up.valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (send) begin
            rd_ptr <= rd_ptr + 1'b1;
         end

         // fill level
         case ({up.valid, send})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase

         // downstream credits
         // pulses come back as the sink frees space
         case ({down.credit, send})
            2'b10:   out_cred <= out_cred + 1'b1;
            2'b01:   out_cred <= out_cred - 1'b1;
            default: out_cred <= out_cred;
         endcase

         // word goes out and its slot is handed back upstream together
         down.valid <= send;
         up.credit  <= send;
      end
   end

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps
`include "uart_macros.svh"

// 8N1 serializer
// one word held in a pending slot while a frame is on the line
// so the next start bit can follow the stop bit directly
module uart_tx (
   input  logic      clk,
   input  logic      rst_n,
   byte_link_if.snk  in,
   output logic      tx
);

   localparam uart_line_pkg::bit_timer_t BIT_END =
      uart_line_pkg::bit_timer_t'(`UART_CLKS_PER_BIT - 1);
   localparam uart_line_pkg::bit_idx_t LAST_BIT =
      uart_line_pkg::bit_idx_t'(`UART_DATA_BITS - 1);

   uart_line_pkg::line_state_e state;
   uart_line_pkg::bit_timer_t  timer;
   uart_line_pkg::bit_idx_t    idx;
   uart_host_pkg::byte_t       shift;
   uart_host_pkg::byte_t       pend_byte;
   logic                       pend_valid;
   logic                       bit_done;
   logic                       load;
   logic                       load_pend;

   // last cycle of the current bit
   assign bit_done = (timer == BIT_END);

   // new frame when idle, or right as a stop bit ends
   assign load = (pend_valid || in.valid) &&
                 ((state == uart_line_pkg::idle) ||
                  (state == uart_line_pkg::stop && bit_done));
   // pending word is older, it goes first
   assign load_pend = load && pend_valid;

   // pending slot control
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pend_valid <= 1'b0;
      end else if (in.valid && !(load && !pend_valid)) begin
         // arriving word not taken straight into the shifter
         pend_valid <= 1'b1;
      end else if (load_pend) begin
         pend_valid <= 1'b0;
      end
   end

   // payload registers
   always_ff @(posedge clk) begin
      if (in.valid) begin
         pend_byte <= in.word.data;
      end
      if (load) begin
         shift <= load_pend ? pend_byte : in.word.data;
      end
   end

   // frame sequencer
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= uart_line_pkg::idle;
         timer     <= '0;
         idx       <= '0;
         tx        <= 1'b1;
         in.credit <= 1'b0;
      end else begin
         // slot freed the moment a word enters the shifter
         in.credit <= load;
         if (load) begin
            // start bit from the next edge on
            state <= uart_line_pkg::start;
            timer <= '0;
            idx   <= '0;
            tx    <= 1'b0;
         end else if (state != uart_line_pkg::idle) begin
            if (!bit_done) begin
               timer <= timer + 1'b1;
            end else begin
               timer <= '0;
               case (state)
                  uart_line_pkg::start: begin
                     state <= uart_line_pkg::data;
                     tx    <= shift[0];
                  end
                  uart_line_pkg::data: begin
                     if (idx == LAST_BIT) begin
                        state <= uart_line_pkg::stop;
                        tx    <= 1'b1;
                     end else begin
                        idx <= idx + 1'b1;
                        // lsb first
                        tx  <= shift[idx + 1'b1];
                     end
                  end
                  // nothing waiting, line stays high
                  default: state <= uart_line_pkg::idle;
               endcase
            end
         end
      end
   end

endmodule

/* uart_rx.sv */
`timescale 1ns/1ps
`include "uart_macros.svh"

// 8N1 deserializer
// timer restarts on each start edge, samples mid bit
// no credit when a word completes means the word is dropped
module uart_rx (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      rx,
   byte_link_if.src  out,
   output logic      overrun
);

   localparam uart_line_pkg::bit_timer_t BIT_END =
      uart_line_pkg::bit_timer_t'(`UART_CLKS_PER_BIT - 1);
   localparam uart_line_pkg::bit_timer_t HALF_END =
      uart_line_pkg::bit_timer_t'(`UART_CLKS_PER_BIT / 2 - 1);
   localparam uart_line_pkg::bit_idx_t LAST_BIT =
      uart_line_pkg::bit_idx_t'(`UART_DATA_BITS - 1);

   uart_line_pkg::line_state_e state;
   uart_line_pkg::bit_timer_t  timer;
   uart_line_pkg::bit_idx_t    idx;
   uart_host_pkg::byte_t       shift;
   uart_host_pkg::credit_cnt_t credits;
   logic                       rx_s1;
   logic                       rx_s2;
   logic                       rx_d;
   logic                       fall;
   logic                       bit_done;
   logic                       stop_sample;
   logic                       spend;

   // rx is asynchronous, two flops plus one for the edge
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rx_s1 <= 1'b1;
         rx_s2 <= 1'b1;
         rx_d  <= 1'b1;
      end else begin
         rx_s1 <= rx;
         rx_s2 <= rx_s1;
         rx_d  <= rx_s2;
      end
   end

   assign fall        = rx_d && !rx_s2;
   assign bit_done    = (timer == BIT_END);
   assign stop_sample = (state == uart_line_pkg::stop) && bit_done;
   // word goes out only against a credit from the buffer
   assign spend       = stop_sample && (credits != '0);

   // payload
   always_ff @(posedge clk) begin
      // lsb arrives first, shift in from the top
      if (state == uart_line_pkg::data && bit_done) begin
         shift <= {rx_s2, shift[`UART_DATA_BITS-1:1]};
      end
      if (stop_sample) begin
         out.word.data      <= shift;
         out.word.frame_err <= !rx_s2;
      end
   end

   // frame tracking and credits
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= uart_line_pkg::idle;
         timer     <= '0;
         idx       <= '0;
         credits   <= uart_host_pkg::credit_cnt_t'(`UART_FIFO_DEPTH);
         out.valid <= 1'b0;
         overrun   <= 1'b0;
      end else begin
         out.valid <= spend;
         overrun   <= stop_sample && (credits == '0);

         case ({out.credit, spend})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits;
         endcase

         case (state)
            uart_line_pkg::idle: begin
               if (fall) begin
                  state <= uart_line_pkg::start;
                  timer <= '0;
               end
            end
            uart_line_pkg::start: begin
               if (timer == HALF_END) begin
                  timer <= '0;
                  idx   <= '0;
                  // still low mid bit, a real start bit
                  // otherwise a glitch, back to idle
                  state <= rx_s2 ? uart_line_pkg::idle : uart_line_pkg::data;
               end else begin
                  timer <= timer + 1'b1;
               end
            end
            uart_line_pkg::data: begin
               if (bit_done) begin
                  timer <= '0;
                  if (idx == LAST_BIT) begin
                     state <= uart_line_pkg::stop;
                  end else begin
                     idx <= idx + 1'b1;
                  end
               end else begin
                  timer <= timer + 1'b1;
               end
            end
            default: begin
               // stop bit sampled, watch for the next start edge
               if (bit_done) begin
                  state <= uart_line_pkg::idle;
                  timer <= '0;
               end else begin
                  timer <= timer + 1'b1;
               end
            end
         endcase
      end
   end

endmodule

/* uart_core.sv */
`timescale 1ns/1ps

// serial port top
// tx: host -> tx_buf -> uart_tx -> line
// rx: line -> uart_rx -> rx_buf -> host
module uart_core (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 tx_valid,
   input  uart_host_pkg::byte_t tx_data,
   output logic                 tx_credit,
   output logic                 tx,
   input  logic                 rx,
   output logic                 rx_valid,
   output uart_host_pkg::byte_t rx_data,
   output logic                 rx_frame_err,
   input  logic                 rx_credit,
   output logic                 rx_overrun
);

   byte_link_if tx_host_l ();
   byte_link_if tx_line_l ();
   byte_link_if rx_line_l ();
   byte_link_if rx_host_l ();

   // host side of the transmit stream
   assign tx_host_l.valid = tx_valid;
   assign tx_host_l.word  = '{data: tx_data, frame_err: 1'b0};
   assign tx_credit       = tx_host_l.credit;

   // host side of the receive stream
   assign rx_valid         = rx_host_l.valid;
   assign rx_data          = rx_host_l.word.data;
   assign rx_frame_err     = rx_host_l.word.frame_err;
   assign rx_host_l.credit = rx_credit;

   // serializer has a single pending slot
   byte_fifo #(.INIT_CREDITS(1)) tx_buf (
      .clk  (clk),
      .rst_n(rst_n),
      .up   (tx_host_l.snk),
      .down (tx_line_l.src)
   );

   uart_tx u_tx (
      .clk  (clk),
      .rst_n(rst_n),
      .in   (tx_line_l.snk),
      .tx   (tx)
   );

   uart_rx u_rx (
      .clk    (clk),
      .rst_n  (rst_n),
      .rx     (rx),
      .out    (rx_line_l.src),
      .overrun(rx_overrun)
   );

   // host grants its credits by pulses, none at reset
   byte_fifo #(.INIT_CREDITS(0)) rx_buf (
      .clk  (clk),
      .rst_n(rst_n),
      .up   (rx_line_l.snk),
      .down (rx_host_l.src)
   );

endmodule

/* rs232_model.sv */
`timescale 1ns/1ps
`include "uart_macros.svh"

// behavioral partner on the serial wires
// drives the DUT rx line, listens on the DUT tx line
// LOGLEVEL 0 quiet, 1 one line per frame, 2 every bit
module rs232_model #(
   parameter int LOGLEVEL = 1,
   parameter int BIT_NS   = `UART_CLKS_PER_BIT * 10
) (
   input  logic tx,
   output logic rx
);

   // idle line is high
   initial rx = 1'b1;

   // one 8N1 frame onto rx
   // stop_bit low forces a framing error at the far end
   task automatic send_frame(input uart_host_pkg::byte_t value, input logic stop_bit);
      if (LOGLEVEL >= 1) begin
         $display("[rs232 %0t] send 0x%02h stop %0b", $time, value, stop_bit);
      end
      rx = 1'b0;
      #(BIT_NS);
      // lsb first
      for (int i = 0; i < `UART_DATA_BITS; i++) begin
         rx = value[i];
         if (LOGLEVEL >= 2) begin
            $display("[rs232 %0t]   rx bit %0d = %0b", $time, i, value[i]);
         end
         #(BIT_NS);
      end
      rx = stop_bit;
      #(BIT_NS);
      // one idle bit, gives a clean start edge even after a low stop bit
      rx = 1'b1;
      #(BIT_NS);
   endtask

   // waits for a start edge on tx, then samples each bit in its middle
   // returns at the middle of the stop bit
   task automatic receive_frame(output uart_host_pkg::byte_t value,
                                output logic start_bit,
                                output logic stop_bit);
      uart_host_pkg::byte_t bits;
      bits = '0;
      @(negedge tx);
      #(BIT_NS / 2);
      start_bit = tx;
      for (int i = 0; i < `UART_DATA_BITS; i++) begin
         #(BIT_NS);
         bits[i] = tx;
         if (LOGLEVEL >= 2) begin
            $display("[rs232 %0t]   tx bit %0d = %0b", $time, i, tx);
         end
      end
      #(BIT_NS);
      stop_bit = tx;
      value    = bits;
      if (LOGLEVEL >= 1) begin
         $display("[rs232 %0t] got 0x%02h start %0b stop %0b",
                  $time, bits, start_bit, stop_bit);
      end
   endtask

endmodule

/* tb_uart.sv */
`timescale 1ns/1ps
`include "uart_macros.svh"

// testbench for uart_core
// host ports driven here
// line side goes through rs232_model
module tb_uart;

   localparam int CLK_NS    = 10;
   localparam int BIT_NS    = `UART_CLKS_PER_BIT * CLK_NS;
   localparam int FRAME_NS  = 10 * BIT_NS;
   localparam int MAX_RECS  = 64;
   localparam int MARGIN_NS = 20000;
   localparam int DEPTH     = `UART_FIFO_DEPTH;
   // right shifting galois taps for x^32 + x^31 + x^29 + x + 1
   localparam logic [31:0] LFSR_TAPS = 32'hD000_0001;

   logic                 clk = 1'b0;
   logic                 rst_n;
   logic                 tx_valid;
   uart_host_pkg::byte_t tx_data;
   logic                 tx_credit;
   logic                 tx;
   logic                 rx;
   logic                 rx_valid;
   uart_host_pkg::byte_t rx_data;
   logic                 rx_frame_err;
   logic                 rx_credit;
   logic                 rx_overrun;

   // kind in [15:12]
   // flag in [8] and byte in [7:0]
   logic [15:0] recs [MAX_RECS];
   int          n_records = 0;

   // host side bookkeeping
   int          tx_sent     = 0;
   int          tx_returned = 0;
   int          overrun_cnt = 0;
   int          exp_overrun = 0;
   logic [31:0] lfsr        = 32'd84748;

   uart_host_pkg::byte_t    exp_tx_q [$];
   uart_host_pkg::byte_t    held_q [$];
   uart_host_pkg::rx_word_t rx_q [$];

   always #(CLK_NS / 2) clk = ~clk;

   uart_core uut (
      .clk         (clk),
      .rst_n       (rst_n),
      .tx_valid    (tx_valid),
      .tx_data     (tx_data),
      .tx_credit   (tx_credit),
      .tx          (tx),
      .rx          (rx),
      .rx_valid    (rx_valid),
      .rx_data     (rx_data),
      .rx_frame_err(rx_frame_err),
      .rx_credit   (rx_credit),
      .rx_overrun  (rx_overrun)
   );

   rs232_model #(.LOGLEVEL(1), .BIT_NS(BIT_NS)) partner (
      .tx(tx),
      .rx(rx)
   );

   task automatic compare(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Mismatch at %0d ns: %s expected 0x%0h actual 0x%0h",
                  $time, name, expected, actual);
         $display("SOME TESTS FAILED");
         $fatal(1, "check on %s failed", name);
      end
   endtask

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
   endfunction

   // one lfsr step per bit taken
   task automatic random_bits(input int n, output int val);
      val = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         val  = (val << 1) | int'(lfsr[0]);
      end
   endtask

   task automatic idle_gap();
      int gap;
      random_bits(4, gap);
      repeat (gap) @(negedge clk);
   endtask

   // credits the host still holds
   function automatic uart_host_pkg::credit_cnt_t host_tx_credits();
      return uart_host_pkg::credit_cnt_t'(DEPTH - tx_sent + tx_returned);
   endfunction

   // starts and ends on a falling edge
   task automatic send_host_byte(input uart_host_pkg::byte_t value);
      while (host_tx_credits() == 0) begin
         @(negedge clk);
      end
      tx_valid = 1'b1;
      tx_data  = value;
      tx_sent <= tx_sent + 1;
      exp_tx_q.push_back(value);
      @(negedge clk);
      tx_valid = 1'b0;
   endtask

   // separate one cycle pulses
   task automatic grant_rx_credit(input int n);
      repeat (n) begin
         rx_credit = 1'b1;
         @(negedge clk);
         rx_credit = 1'b0;
         @(negedge clk);
      end
   endtask

   task automatic expect_rx_word(input uart_host_pkg::byte_t value, input logic err);
      uart_host_pkg::rx_word_t w;
      while (rx_q.size() == 0) begin
         @(negedge clk);
      end
      w = rx_q.pop_front();
      compare("rx_data", 32'(value), 32'(w.data));
      compare("rx_frame_err", 32'(err), 32'(w.frame_err));
   endtask

   // wait for every sent byte on the line
   // then all credits must be home
   task automatic drain_tx();
      while (exp_tx_q.size() != 0) begin
         @(negedge clk);
      end
      @(negedge clk);
      compare("tx credits after drain", 32'(DEPTH), 32'(host_tx_credits()));
   endtask

   // host outputs sampled on the falling edge
   always @(negedge clk) begin
      if (rst_n) begin
         if (rx_valid) begin
            rx_q.push_back({rx_data, rx_frame_err});
         end
         if (rx_overrun) begin
            overrun_cnt <= overrun_cnt + 1;
         end
         if (tx_credit) begin
            tx_returned <= tx_returned + 1;
         end
      end
   end

   // host credit count must stay within 0..DEPTH
   always @(posedge clk) begin : credit_bound
      int avail;
      avail = DEPTH - tx_sent + tx_returned;
      if (rst_n) begin
         compare("tx credit count in range", 32'd1,
                 32'((avail >= 0) && (avail <= DEPTH)));
      end
   end

   // frames coming out of the DUT in send order
   initial begin : tx_line_watch
      uart_host_pkg::byte_t got;
      logic                 start_bit;
      logic                 stop_bit;
      forever begin
         partner.receive_frame(got, start_bit, stop_bit);
         if (exp_tx_q.size() == 0) begin
            $display("Frame 0x%02h appeared on tx at %0d ns with no byte sent", got, $time);
            $display("SOME TESTS FAILED");
            $fatal(1, "unexpected tx frame");
         end else begin
            compare("tx start bit", 32'd0, 32'(start_bit));
            compare("tx data", 32'(exp_tx_q.pop_front()), 32'(got));
            compare("tx stop bit", 32'd1, 32'(stop_bit));
         end
      end
   end

   // 12 frame times per record
   initial begin : watchdog
      wait (n_records > 0);
      #(n_records * 12 * FRAME_NS + MARGIN_NS);
      $display("Run timed out after %0d ns with %0d records", $time, n_records);
      $display("SOME TESTS FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin : main
      logic [3:0]           kind;
      logic                 flag;
      uart_host_pkg::byte_t value;
      int                   n;
      int                   count;
      rst_n     = 1'b0;
      tx_valid  = 1'b0;
      tx_data   = '0;
      rx_credit = 1'b0;
      // unused slots keep kind 0 and end the list
      foreach (recs[i]) begin
         recs[i] = {4'h0, 12'(i)};
      end
      $readmemh("uart_patterns.hex", recs);
      count = 0;
      while (count < MAX_RECS && recs[count][15:12] != 4'd0) begin
         count++;
      end
      if (count == 0) begin
         $display("No records found in uart_patterns.hex");
         $display("SOME TESTS FAILED");
         $fatal(1, "empty pattern file");
      end
      n_records = count;

      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      for (int i = 0; i < n_records; i++) begin
         kind  = recs[i][15:12];
         flag  = recs[i][8];
         value = recs[i][7:0];
         case (kind)
            4'd1: begin
               idle_gap();
               send_host_byte(value);
            end
            // burst with no gap
            4'd2: send_host_byte(value);
            4'd3: begin
               idle_gap();
               partner.send_frame(value, !flag);
               // back onto a falling edge
               #1;
               @(negedge clk);
               compare("rx_valid before credit", 32'd0, 32'(rx_q.size()));
               grant_rx_credit(1);
               expect_rx_word(value, flag);
            end
            4'd4: begin
               partner.send_frame(value, 1'b1);
               #1;
               @(negedge clk);
               if (flag) begin
                  exp_overrun++;
               end else begin
                  held_q.push_back(value);
               end
            end
            4'd5: begin
               compare("rx_valid with no credit", 32'd0, 32'(rx_q.size()));
               compare("rx_overrun pulses", 32'(exp_overrun), 32'(overrun_cnt));
               n = held_q.size();
               grant_rx_credit(n);
               repeat (n) begin
                  expect_rx_word(held_q.pop_front(), 1'b0);
               end
            end
            4'd6: drain_tx();
            default: begin
               $display("Record %0d has unknown kind %0d", i, kind);
               $display("SOME TESTS FAILED");
               $fatal(1, "bad pattern record");
            end
         endcase
      end

      // nothing extra on the receive side
      repeat (4) @(negedge clk);
      compare("rx_overrun pulses at end", 32'(exp_overrun), 32'(overrun_cnt));
      compare("rx_valid extra words", 32'd0, 32'(rx_q.size()));
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

/* uart_patterns.hex */
// kind flag byte: 1 tx, 2 tx burst, 3 rx (flag: low stop bit, frame_err expected)
// 4 rx with no credit (flag: frame dropped), 5 grant and check held bytes, 6 wait tx drained
1055
10a3
6000
2001
2080
20ff
207e
2012
2034
2056
2078
6000
30c4
315a
303c
31ff
4011
4022
4033
4044
4155
5000
1069
6000

/* tb.f */
+incdir+.
uart_line_pkg.sv
uart_host_pkg.sv
byte_link_if.sv
byte_fifo.sv
uart_tx.sv
uart_rx.sv
uart_core.sv
rs232_model.sv
tb_uart.sv

/* Makefile */
# Verilator build and run of the uart testbench

VERILATOR ?= verilator
TOP       ?= tb_uart
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PATTERNS  ?= uart_patterns.hex
PASS_STR  ?= ALL TESTS PASSED
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := uart_macros.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(PATTERNS)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
